//--- src/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  // Bit time is shortened for simulation.
  localparam int bit_cycles      = 16;
  localparam int half_bit_cycles = bit_cycles / 2;
  localparam int data_bits       = 8;
  // Start, data, parity and stop.
  localparam int frame_bits      = data_bits + 3;
  localparam int gap_cycles      = 16;

  localparam int cmd_width       = 16;
  localparam int cmd_rw_bit      = cmd_width - 1;

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_send_addr  = 3'd1;
  localparam logic [2:0] st_gap        = 3'd2;
  localparam logic [2:0] st_send_data  = 3'd3;
  localparam logic [2:0] st_await_resp = 3'd4;
  localparam logic [2:0] st_done       = 3'd5;

  typedef logic [data_bits-1:0]          byte_t;
  typedef logic [$clog2(bit_cycles)-1:0] cnt_t;

endpackage

`default_nettype wire

//--- src/uart_rx_if.sv
`timescale 1ns/100ps
`default_nettype none

interface uart_rx_if
  import uart_cmd_pkg::*;
();

  logic  enable;
  byte_t data;
  logic  valid;
  // Only meaningful while valid is high.
  logic  parity_err;

  modport ctrl (output enable, input data, input valid, input parity_err);

  modport phy (input enable, output data, output valid, output parity_err);

endinterface

`default_nettype wire

//--- src/uart_tx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  tx_done,
  output logic  tx
);

  logic                          busy;
  cnt_t                          bit_cnt;
  logic [$clog2(frame_bits)-1:0] bit_idx;
  byte_t                         data_q;
  logic                          bit_end;
  logic                          next_bit;

  assign bit_end = busy && (bit_cnt == bit_cycles - 1);
  assign tx_done = bit_end && (bit_idx == frame_bits - 1);

  // Line level for the bit after the current one.
  always_comb
  begin
    if (bit_idx < data_bits)
      next_bit = data_q[bit_idx[$clog2(data_bits)-1:0]];
    else if (bit_idx == data_bits)
      next_bit = ^data_q;
    else
      next_bit = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (tx_start && !busy)
    begin
      busy    <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b0;
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (tx_done)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= next_bit;
      end
    end
    else if (busy)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (tx_start && !busy)
      data_q <= tx_byte;
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx);

  // The controller must wait for tx_done before the next frame.
  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !busy);

endmodule

`default_nettype wire

//--- src/uart_rx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rx,
  uart_rx_if.phy rx_link
);

  logic                          rx_s1;
  logic                          rx_s2;
  logic                          rx_s3;
  logic                          active;
  cnt_t                          sample_cnt;
  logic [$clog2(frame_bits)-1:0] bit_idx;
  byte_t                         shift_q;
  logic                          parity_q;
  logic                          sample;
  logic                          frame_err;

  // First sample lands mid start bit, the rest one bit time apart.
  assign sample = active && ((bit_idx == 0) ? (sample_cnt == half_bit_cycles - 1)
                                            : (sample_cnt == bit_cycles - 1));

  // Odd total of ones or a low stop bit.
  assign frame_err = (^shift_q ^ parity_q) | ~rx_s2;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active             <= 1'b0;
      sample_cnt         <= '0;
      bit_idx            <= '0;
      rx_link.valid      <= 1'b0;
      rx_link.parity_err <= 1'b0;
    end
    else
    begin
      rx_link.valid <= 1'b0;
      if (!active)
      begin
        if (rx_link.enable && rx_s3 && !rx_s2)
        begin
          active     <= 1'b1;
          sample_cnt <= '0;
          bit_idx    <= '0;
        end
      end
      else if (sample)
      begin
        sample_cnt <= '0;
        bit_idx    <= bit_idx + 1'b1;
        // Back to hunting when the start bit has gone high again.
        if (bit_idx == 0 && rx_s2)
          active <= 1'b0;
        else if (bit_idx == frame_bits - 1)
        begin
          active             <= 1'b0;
          rx_link.valid      <= 1'b1;
          rx_link.parity_err <= frame_err;
        end
      end
      else
        sample_cnt <= sample_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && bit_idx >= 1 && bit_idx <= data_bits)
      shift_q <= {rx_s2, shift_q[data_bits-1:1]};
    if (sample && bit_idx == data_bits + 1)
      parity_q <= rx_s2;
    if (sample && bit_idx == frame_bits - 1)
      rx_link.data <= shift_q;
  end

  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_link.valid |=> !rx_link.valid);

endmodule

`default_nettype wire

//--- src/uart_cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [cmd_width-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output byte_t                tx_byte,
  input  logic                 tx_done,
  uart_rx_if.ctrl              rx_link,
  output byte_t                read_data,
  output logic                 read_rdy,
  output logic                 read_err
);

  logic [2:0]                    state;
  logic [cmd_width-1:0]          cmd_q;
  logic [$clog2(gap_cycles)-1:0] gap_cnt;
  logic                          accept;
  logic                          gap_end;

  // The done cycle already takes a new command.
  assign cmd_rdy        = (state == st_idle) || (state == st_done);
  assign accept         = cmd_vld && cmd_rdy;
  assign gap_end        = (state == st_gap) && (gap_cnt == gap_cycles - 1);
  assign rx_link.enable = (state == st_await_resp);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      gap_cnt  <= '0;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        st_idle, st_done:
        begin
          if (accept)
          begin
            state    <= st_send_addr;
            tx_start <= 1'b1;
          end
          else
            state <= st_idle;
        end
        st_send_addr:
        begin
          gap_cnt <= '0;
          // Writes go on to the data byte, reads wait for the answer.
          if (tx_done)
            state <= cmd_q[cmd_rw_bit] ? st_gap : st_await_resp;
        end
        st_gap:
        begin
          if (gap_end)
          begin
            state    <= st_send_data;
            tx_start <= 1'b1;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        st_send_data:
        begin
          if (tx_done)
            state <= st_done;
        end
        st_await_resp:
        begin
          if (rx_link.valid)
          begin
            state    <= st_done;
            read_rdy <= 1'b1;
            read_err <= rx_link.parity_err;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= cmd_in[cmd_rw_bit -: data_bits];
    end
    else if (gap_end)
      tx_byte <= cmd_q[data_bits-1:0];
    if (rx_link.enable && rx_link.valid)
      read_data <= rx_link.data;
  end

  a_read_rdy_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> $past(rx_link.enable) && !cmd_q[cmd_rw_bit]);

  a_tx_rx_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(tx_start && rx_link.enable));

endmodule

`default_nettype wire

//--- src/uart_cmd_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [cmd_width-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output byte_t                read_data,
  output logic                 read_rdy,
  output logic                 read_err
);

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_done;

  uart_rx_if rx_link ();

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_link   (rx_link.ctrl),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx_frame u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_link (rx_link.phy)
  );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen
(
  output logic clk
);

  localparam int half_period_ns = 50;

  initial
  begin
    clk = 1'b0;
    forever
      #half_period_ns clk = ~clk;
  end

endmodule

`default_nettype wire

//--- verif/uart_cmd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_tb
  import uart_cmd_pkg::*;
();

  localparam logic [31:0] seed       = 32'h3eaa_2abe;
  localparam int          num_cmds   = 20;
  localparam int          wait_limit = 4 * frame_bits * bit_cycles + gap_cycles;

  logic                 clk;
  logic                 rst_n;
  logic [cmd_width-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  byte_t                read_data;
  logic                 read_rdy;
  logic                 read_err;

  int                   errors;
  int                   exp_frames;
  logic [cmd_width-1:0] cmd;
  byte_t                mon_payload[$];
  logic                 mon_parity[$];
  logic                 mon_stop[$];
  byte_t                got_data[$];
  logic                 got_err[$];
  logic                 mon_busy;
  int                   mon_cnt;
  int                   bit_pos;
  byte_t                mon_shift;
  logic                 mon_par;

  tb_clk_gen clk_gen0 (.clk(clk));

  uart_cmd_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  // The line monitor samples tx in the middle of every bit.
  always @(negedge clk)
  begin
    if (!rst_n)
      mon_busy = 1'b0;
    else if (!mon_busy)
    begin
      if (!tx)
      begin
        mon_busy = 1'b1;
        mon_cnt  = 0;
      end
    end
    else
    begin
      mon_cnt = mon_cnt + 1;
      if (mon_cnt % bit_cycles == half_bit_cycles)
      begin
        bit_pos = mon_cnt / bit_cycles;
        if (bit_pos >= 1 && bit_pos <= data_bits)
          mon_shift[bit_pos-1] = tx;
        else if (bit_pos == data_bits + 1)
          mon_par = tx;
        else if (bit_pos == frame_bits - 1)
        begin
          mon_payload.push_back(mon_shift);
          mon_parity.push_back(mon_par);
          mon_stop.push_back(tx);
          mon_busy = 1'b0;
        end
      end
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      got_data.push_back(read_data);
      got_err.push_back(read_err);
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    begin
      if (expected !== actual)
      begin
        $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        errors++;
      end
    end
  endtask

  task automatic finish_run();
    begin
      $display("Errors: %0d", errors);
      if (errors == 0)
        $display("Result: PASSED");
      else
        $display("Result: FAILED");
      $finish;
    end
  endtask

  task automatic report_timeout(input string what);
    begin
      $display("Timeout: %s never came", what);
      errors++;
      finish_run();
    end
  endtask

  task automatic wait_cmd_rdy(input string what);
    int n;
    begin
      n = 0;
      while (!cmd_rdy && n < wait_limit)
      begin
        @(negedge clk);
        n++;
      end
      if (!cmd_rdy)
        report_timeout(what);
    end
  endtask

  task automatic wait_frames(input int count, input string what);
    int n;
    begin
      n = 0;
      while (mon_payload.size() < count && n < wait_limit)
      begin
        @(negedge clk);
        n++;
      end
      if (mon_payload.size() < count)
        report_timeout(what);
    end
  endtask

  task automatic wait_results(input int count, input string what);
    int n;
    begin
      n = 0;
      while (got_data.size() < count && n < wait_limit)
      begin
        @(negedge clk);
        n++;
      end
      if (got_data.size() < count)
        report_timeout(what);
    end
  endtask

  // Drives one response frame on rx and gives a bad frame odd parity.
  task automatic send_response(input byte_t data, input logic bad_parity);
    logic [frame_bits-1:0] bits;
    begin
      bits = {1'b1, ^data ^ bad_parity, data, 1'b0};
      for (int i = 0; i < frame_bits; i++)
      begin
        rx = bits[i];
        repeat (bit_cycles) @(negedge clk);
      end
    end
  endtask

  task automatic run_cmd(input string name, input logic [cmd_width-1:0] value,
                         input byte_t resp, input logic bad_parity, input logic offer_busy);
    int    base;
    int    results;
    logic  is_read;
    byte_t exp_bytes[$];
    begin
      base    = mon_payload.size();
      results = got_data.size();
      is_read = !value[cmd_rw_bit];
      wait_cmd_rdy({"cmd_rdy before ", name});
      cmd_in  = value;
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      // The high byte always goes out and a write adds the data byte.
      exp_bytes.push_back(value[15:8]);
      if (!is_read)
        exp_bytes.push_back(value[7:0]);
      exp_frames += exp_bytes.size();
      if (offer_busy)
      begin
        check_value({name, " cmd_rdy while busy"}, 0, cmd_rdy);
        cmd_in  = ~value;
        cmd_vld = 1'b1;
        repeat (4) @(negedge clk);
        cmd_vld = 1'b0;
      end
      if (is_read)
      begin
        wait_frames(base + 1, {"address frame for ", name});
        // One idle bit time lets the master open its receiver.
        repeat (bit_cycles) @(negedge clk);
        send_response(resp, bad_parity);
        wait_results(results + 1, {"read_rdy for ", name});
      end
      wait_cmd_rdy({"cmd_rdy after ", name});
      check_value({name, " frame count"}, exp_frames, mon_payload.size());
      for (int i = 0; i < exp_bytes.size(); i++)
      begin
        if (base + i < mon_payload.size())
        begin
          check_value({name, " payload"}, exp_bytes[i], mon_payload[base+i]);
          check_value({name, " parity"}, $countones(exp_bytes[i]) % 2,
                      mon_parity[base+i]);
          check_value({name, " stop bit"}, 1, mon_stop[base+i]);
        end
      end
      check_value({name, " read count"}, results + int'(is_read), got_data.size());
      if (is_read && got_data.size() > results)
      begin
        check_value({name, " read_data"}, resp, got_data[results]);
        check_value({name, " read_err"}, bad_parity, got_err[results]);
      end
    end
  endtask

  initial
  begin
    errors     = 0;
    exp_frames = 0;
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    rx         = 1'b1;
    void'($urandom(seed));
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset tx", 1, tx);
    check_value("reset cmd_rdy", 1, cmd_rdy);
    check_value("reset read_rdy", 0, read_rdy);
    check_value("reset read_err", 0, read_err);

    cmd = {1'b1, 15'($urandom)};
    run_cmd("write", cmd, 8'h00, 1'b0, 1'b0);
    cmd = {1'b0, 15'($urandom)};
    run_cmd("read", cmd, byte_t'($urandom), 1'b0, 1'b0);
    cmd = {1'b0, 15'($urandom)};
    run_cmd("bad parity read", cmd, byte_t'($urandom), 1'b1, 1'b0);
    cmd = {1'b1, 15'($urandom)};
    run_cmd("busy write", cmd, 8'h00, 1'b0, 1'b1);
    cmd = {1'b0, 15'($urandom)};
    run_cmd("busy read", cmd, byte_t'($urandom), 1'b0, 1'b1);

    for (int n = 0; n < num_cmds; n++)
    begin
      cmd = 16'($urandom);
      run_cmd($sformatf("random %0d", n), cmd, byte_t'($urandom), ($urandom % 4) == 0,
              1'b0);
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- build.f
src/uart_cmd_pkg.sv
src/uart_rx_if.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_cmd_ctrl.sv
src/uart_cmd_top.sv
verif/tb_clk_gen.sv
verif/uart_cmd_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module uart_cmd_tb \
  -f build.f -o uart_cmd_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/uart_cmd_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
